/* Bender.yml */
package:
  name: tree_arbiter

sources:
  - target: any(rtl, test)
    files:
      - src/arbiterPkg.sv
      - src/clientPort.sv
      - src/arbitCell.sv
      - src/ownerMux.sv
      - src/treeArbiter.sv
  - target: test
    files:
      - test/treeArbiter_properties.sv
      - test/treeArbiter_tb.sv

/* flist.f */
src/arbiterPkg.sv
src/clientPort.sv
src/arbitCell.sv
src/ownerMux.sv
src/treeArbiter.sv
test/treeArbiter_properties.sv
test/treeArbiter_tb.sv

/* src/arbitCell.sv */
`timescale 1ns/1ps
`default_nettype none

// one node of the arbitration tree.
// the cell sits between two children and a parent. when it holds the token
// it may pass it down to a requesting child, otherwise it asks its parent.
// a leaf gives the token back up once both children had their turn, which
// keeps one busy subtree from starving the other.
module arbitCell
    import arbiterPkg::*;
#(
    parameter bit isRoot = 1'b0
) (
    input  logic  clk,
    input  logic  reset,
    input  phaseT leftPhase,
    input  phaseT rightPhase,
    input  logic  parentGrant,
    output logic  leftGrant,
    output logic  rightGrant,
    output phaseT parentPhase
);

    // set while the token rests in this cell and no child holds it.
    logic holdToken;

    // set when the left child was the last one to get the token.
    logic prevLeft;

    // a processed flag says that a child has used the token since the
    // parent last handed it to this cell.
    logic processedLeft;
    logic processedRight;

    logic leftReq;
    logic rightReq;
    logic requesting;
    logic childOwns;
    logic giveChild;
    logic childReleases;
    logic mustGiveParent;

    // --------------------
    // decisions
    // --------------------

    assign leftReq    = (leftPhase == phaseRequest);
    assign rightReq   = (rightPhase == phaseRequest);
    assign requesting = leftReq || rightReq;

    // a descendant is using the token right now.
    assign childOwns = (leftPhase == phaseLock) || (rightPhase == phaseLock);

    // a child hands the token back to us in this cycle.
    assign childReleases = (leftPhase == phaseRelease) || (rightPhase == phaseRelease);

    // a leaf owes the token to its parent when no child is left that asks
    // and has not yet had its turn. the root never owes anything.
    assign mustGiveParent = (processedLeft || !leftReq)
        && (processedRight || !rightReq) && !isRoot;

    // the left child wins when it asks and either the right one does not,
    // or the right one was served last.
    assign leftGrant = holdToken && !mustGiveParent && leftReq
        && (!rightReq || !prevLeft);

    // the mirror image for the right child.
    assign rightGrant = holdToken && !mustGiveParent && rightReq
        && (!leftReq || prevLeft);

    assign giveChild = leftGrant || rightGrant;

    // what the parent sees of this subtree.
    // a missing token with a waiting child turns into a request, a locked
    // descendant into lock, and a leaf that has nothing more to do with
    // its token gives it back with release.
    always_comb begin
        if (!holdToken && requesting) begin
            parentPhase = phaseRequest;
        end else if (childOwns) begin
            parentPhase = phaseLock;
        end else if (holdToken && !isRoot && (mustGiveParent || !requesting)) begin
            parentPhase = phaseRelease;
        end else begin
            parentPhase = phaseIdle;
        end
    end

    // --------------------
    // token state
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            // only the root starts with the token.
            holdToken      <= isRoot;
            prevLeft       <= 1'b0;
            processedLeft  <= 1'b0;
            processedRight <= 1'b0;
        end else begin
            // the token comes from the parent or a child, and leaves to a child
            // or back up to the parent.
            if (parentGrant) begin
                holdToken <= 1'b1;
            end else if (giveChild) begin
                holdToken <= 1'b0;
            end else if (childReleases) begin
                holdToken <= 1'b1;
            end else if (parentPhase == phaseRelease) begin
                holdToken <= 1'b0;
            end

            // remember which way the token went last.
            if (leftGrant) begin
                prevLeft <= 1'b1;
            end else if (rightGrant) begin
                prevLeft <= 1'b0;
            end

            // a fresh token from the parent starts a new round for both children.
            if (parentGrant) begin
                processedLeft  <= 1'b0;
                processedRight <= 1'b0;
            end else if (leftPhase == phaseRelease) begin
                processedLeft <= 1'b1;
            end else if (rightPhase == phaseRelease) begin
                processedRight <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/arbiterPkg.sv */
`default_nettype none

// shared types and sizes for the token-passing tree arbiter.
package arbiterPkg;

    // --------------------
    // sizes
    // --------------------

    // the tree has two leaves with two clients each, so four clients in all.
    localparam int NumClients = 4;

    // width of the address that a client puts on the shared bus.
    localparam int AddrWidth = 8;

    // width of the data word that a client puts on the shared bus.
    localparam int DataWidth = 16;

    // --------------------
    // token link phases
    // --------------------

    // every link in the tree carries one of these four phases.
    // a child asks for the token with request, holds it with lock and
    // hands it back with release; idle means the child has no interest.
    // the encoding follows the order in which a link walks through them.
    typedef enum logic [1:0] {
        phaseIdle    = 2'd0,
        phaseRequest = 2'd1,
        phaseLock    = 2'd2,
        phaseRelease = 2'd3
    } phaseT;

    // --------------------
    // bus payloads
    // --------------------

    // the address payload that travels through the bus multiplexer.
    typedef logic [AddrWidth-1:0] addrT;

    // the data payload that travels through the bus multiplexer.
    typedef logic [DataWidth-1:0] dataT;

endpackage

`default_nettype wire

/* src/clientPort.sv */
`timescale 1ns/1ps
`default_nettype none

// a client port sits between one bus client and its leaf cell.
// it turns the four-phase req/ack handshake of the client into the
// idle, request, lock and release phases of the token tree.
module clientPort
    import arbiterPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  req,
    input  logic  grant,
    output logic  ack,
    output phaseT childPhase
);

    // the port state is also the phase that the leaf cell sees.
    phaseT state;
    phaseT stateNext;
    logic  ackNext;

    // --------------------
    // next state
    // --------------------

    always_comb begin
        stateNext = state;
        ackNext   = ack;
        case (state)
            phaseIdle: begin
                // a raised req starts a new request towards the tree.
                if (req) begin
                    stateNext = phaseRequest;
                end
            end
            phaseRequest: begin
                // the grant pulse hands us the token, so the client owns the bus.
                if (grant) begin
                    stateNext = phaseLock;
                    ackNext   = 1'b1;
                end
            end
            phaseLock: begin
                // the client keeps the token for as long as it holds req.
                if (!req) begin
                    stateNext = phaseRelease;
                    ackNext   = 1'b0;
                end
            end
            phaseRelease: begin
                // release is shown to the leaf for exactly one cycle.
                stateNext = phaseIdle;
            end
            default: begin
                stateNext = phaseIdle;
                ackNext   = 1'b0;
            end
        endcase
    end

    // --------------------
    // state register
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= phaseIdle;
            ack   <= 1'b0;
        end else begin
            state <= stateNext;
            ack   <= ackNext;
        end
    end

    assign childPhase = state;

endmodule

`default_nettype wire

/* src/ownerMux.sv */
`timescale 1ns/1ps
`default_nettype none

// registers the payload of the client that owns the bus.
// owner is the one-hot ack vector, so at most one payload is picked.
module ownerMux
    import arbiterPkg::*;
#(
    parameter type payloadT = logic
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [NumClients-1:0] owner,
    input  payloadT               payload0,
    input  payloadT               payload1,
    input  payloadT               payload2,
    input  payloadT               payload3,
    output logic                  valid,
    output payloadT               held
);

    payloadT selected;

    // with no owner the bus shows zero.
    always_comb begin
        case (owner)
            4'b0001: selected = payload0;
            4'b0010: selected = payload1;
            4'b0100: selected = payload2;
            4'b1000: selected = payload3;
            default: selected = '0;
        endcase
    end

    // the bus lags the owner by one cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
            held  <= '0;
        end else begin
            valid <= |owner;
            held  <= selected;
        end
    end

endmodule

`default_nettype wire

/* src/treeArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// four-client tree arbiter for one shared bus.
// clients 0 and 1 sit under the first leaf, clients 2 and 3 under the
// second, and both leaves hang from the root, which starts with the token.
module treeArbiter
    import arbiterPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [NumClients-1:0] clientReq,
    output logic [NumClients-1:0] clientAck,
    input  addrT                  clientAddr0,
    input  addrT                  clientAddr1,
    input  addrT                  clientAddr2,
    input  addrT                  clientAddr3,
    input  dataT                  clientData0,
    input  dataT                  clientData1,
    input  dataT                  clientData2,
    input  dataT                  clientData3,
    output logic                  busValid,
    output addrT                  busAddr,
    output dataT                  busData
);

    // --------------------
    // client ports
    // --------------------

    phaseT                  clientPhase [NumClients];
    logic [NumClients-1:0]  clientGrant;

    for (genvar i = 0; i < NumClients; i++) begin : genPort
        clientPort port_i (
            .clk        (clk),
            .reset      (reset),
            .req        (clientReq[i]),
            .grant      (clientGrant[i]),
            .ack        (clientAck[i]),
            .childPhase (clientPhase[i])
        );
    end

    // --------------------
    // tree
    // --------------------

    // the link between each leaf and the root.
    phaseT       leafPhase [2];
    logic [1:0]  leafGrant;

    arbitCell #(.isRoot(1'b0)) leaf0_i (
        .clk         (clk),
        .reset       (reset),
        .leftPhase   (clientPhase[0]),
        .rightPhase  (clientPhase[1]),
        .parentGrant (leafGrant[0]),
        .leftGrant   (clientGrant[0]),
        .rightGrant  (clientGrant[1]),
        .parentPhase (leafPhase[0])
    );

    arbitCell #(.isRoot(1'b0)) leaf1_i (
        .clk         (clk),
        .reset       (reset),
        .leftPhase   (clientPhase[2]),
        .rightPhase  (clientPhase[3]),
        .parentGrant (leafGrant[1]),
        .leftGrant   (clientGrant[2]),
        .rightGrant  (clientGrant[3]),
        .parentPhase (leafPhase[1])
    );

    // the root has no parent, so its grant input stays low.
    arbitCell #(.isRoot(1'b1)) root_i (
        .clk         (clk),
        .reset       (reset),
        .leftPhase   (leafPhase[0]),
        .rightPhase  (leafPhase[1]),
        .parentGrant (1'b0),
        .leftGrant   (leafGrant[0]),
        .rightGrant  (leafGrant[1]),
        .parentPhase ()
    );

    // --------------------
    // bus
    // --------------------

    // busValid comes from the data instance alone.
    ownerMux #(.payloadT(addrT)) addrMux_i (
        .clk      (clk),
        .reset    (reset),
        .owner    (clientAck),
        .payload0 (clientAddr0),
        .payload1 (clientAddr1),
        .payload2 (clientAddr2),
        .payload3 (clientAddr3),
        .valid    (),
        .held     (busAddr)
    );

    ownerMux #(.payloadT(dataT)) dataMux_i (
        .clk      (clk),
        .reset    (reset),
        .owner    (clientAck),
        .payload0 (clientData0),
        .payload1 (clientData1),
        .payload2 (clientData2),
        .payload3 (clientData3),
        .valid    (busValid),
        .held     (busData)
    );

endmodule

`default_nettype wire

/* test/treeArbiter_properties.sv */
`timescale 1ns/1ps
`default_nettype none

// handshake and grant rules of the tree arbiter, checked at every clock edge.
// the module is bound into treeArbiter and only watches its signals.
module treeArbiter_properties
    import arbiterPkg::*;
(
    input logic                  clk,
    input logic                  reset,
    input logic [NumClients-1:0] clientReq,
    input logic [NumClients-1:0] clientAck
);

    // number of assertion failures seen so far.
    int errorCount = 0;

    // only one client may own the shared bus at a time.
    oneOwner: assert property (@(posedge clk) disable iff (reset) $onehot0(clientAck))
        else begin
            $error("more than one client holds ack");
            errorCount++;
        end

    for (genvar i = 0; i < NumClients; i++) begin : genClient

        // ack may only rise for a client that was asking for the bus.
        ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
            $rose(clientAck[i]) |-> $past(clientReq[i]))
            else begin
                $error("client %0d got ack without req", i);
                errorCount++;
            end

        // once req is seen low, ack is gone one cycle later.
        ackFollowsReq: assert property (@(posedge clk) disable iff (reset)
            $fell(clientReq[i]) |=> !clientAck[i])
            else begin
                $error("client %0d kept ack after dropping req", i);
                errorCount++;
            end
    end

endmodule

`default_nettype wire

/* test/treeArbiter_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// directed tests for the four-client tree arbiter.
module treeArbiter_tb
    import arbiterPkg::*;
();

    localparam int ClkPeriod    = 100;
    localparam int ResetCycles  = 16;
    localparam int AckLimit     = 20;

    // cycle budgets of the tests, also used as their loop limits.
    localparam int SingleBudget  = NumClients * 40;
    localparam int MutualBudget  = 100;
    localparam int StarveBudget  = 200;
    localparam int SiblingBudget = 100;
    localparam int BackBudget    = 100;
    localparam int TestCycles    = ResetCycles + 10 + SingleBudget + MutualBudget
        + StarveBudget + SiblingBudget + BackBudget;

    logic                  clk;
    logic                  reset;
    logic [NumClients-1:0] clientReq;
    logic [NumClients-1:0] clientAck;
    addrT                  clientAddr [NumClients];
    dataT                  clientData [NumClients];
    logic                  busValid;
    addrT                  busAddr;
    dataT                  busData;

    // what the DUT saw in the cycle before the last edge.
    logic [NumClients-1:0] prevAck;
    addrT                  prevAddr [NumClients];
    dataT                  prevData [NumClients];

    logic [31:0] rngState;
    int          grantLog [$];
    int          testErrors;
    int          assertSeen;
    int          passCount;
    int          failCount;

    treeArbiter dut_i (
        .clk         (clk),
        .reset       (reset),
        .clientReq   (clientReq),
        .clientAck   (clientAck),
        .clientAddr0 (clientAddr[0]),
        .clientAddr1 (clientAddr[1]),
        .clientAddr2 (clientAddr[2]),
        .clientAddr3 (clientAddr[3]),
        .clientData0 (clientData[0]),
        .clientData1 (clientData[1]),
        .clientData2 (clientData[2]),
        .clientData3 (clientData[3]),
        .busValid    (busValid),
        .busAddr     (busAddr),
        .busData     (busData)
    );

    bind treeArbiter treeArbiter_properties props_i (
        .clk         (clk),
        .reset       (reset),
        .clientReq   (clientReq),
        .clientAck   (clientAck)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // the run is cut off at twice the budget of all tests.
    initial begin
        #(TestCycles * ClkPeriod * 2);
        $display("watchdog expired before the tests finished");
        $display("sim failed");
        $finish;
    end

    // --------------------
    // helpers
    // --------------------

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic logMismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("[FAIL] %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        testErrors++;
    endtask

    task automatic reportProblem(input string msg);
        $display("error at %0t: %s", $time, msg);
        testErrors++;
    endtask

    // a client gets fresh random address and data before it asks.
    task automatic newPayload(input int idx);
        rngState = xorshift(rngState);
        clientAddr[idx] = rngState[AddrWidth-1:0];
        rngState = xorshift(rngState);
        clientData[idx] = rngState[31:32-DataWidth];
    endtask

    // one clock cycle; returns 1 ns after the edge, where inputs are driven.
    // every cycle checks exclusion and that the bus shows last cycle's owner.
    task automatic clockStep();
        logic expValid;
        addrT expAddr;
        dataT expData;
        int   idx;
        prevAck = clientAck;
        for (idx = 0; idx < NumClients; idx++) begin
            prevAddr[idx] = clientAddr[idx];
            prevData[idx] = clientData[idx];
        end
        @(posedge clk);
        #1;
        expValid = |prevAck;
        expAddr  = '0;
        expData  = '0;
        for (idx = 0; idx < NumClients; idx++) begin
            if ($onehot(prevAck) && prevAck[idx]) begin
                expAddr = prevAddr[idx];
                expData = prevData[idx];
            end
        end
        if ((clientAck & (clientAck - 1'b1)) != '0) begin
            reportProblem($sformatf("several acks high at once: %b", clientAck));
        end
        if (busValid !== expValid) logMismatch("busValid", expValid, busValid);
        if (busAddr !== expAddr) logMismatch("busAddr", expAddr, busAddr);
        if (busData !== expData) logMismatch("busData", expData, busData);
    endtask

    task automatic waitIdle(input int cycles);
        repeat (cycles) clockStep();
    endtask

    // plays the clients in mask: each asks as soon as it may, keeps the bus
    // for holdCycles and asks at most perClient times. after grantGoal grants
    // no new request starts, and the task returns once all handshakes closed.
    task automatic serveClients(input logic [NumClients-1:0] mask, input int holdCycles,
                                input int perClient, input int grantGoal, input int limit);
        int                    held [NumClients];
        int                    served [NumClients];
        int                    idx;
        int                    cycles;
        logic                  draining;
        logic [NumClients-1:0] lastAck;
        grantLog.delete();
        for (idx = 0; idx < NumClients; idx++) begin
            held[idx]   = 0;
            served[idx] = 0;
        end
        cycles   = 0;
        draining = 1'b0;
        while ((!draining || clientReq != '0 || clientAck != '0) && cycles < limit) begin
            for (idx = 0; idx < NumClients; idx++) begin
                if (mask[idx]) begin
                    if (clientReq[idx] && clientAck[idx]) begin
                        held[idx]++;
                        if (held[idx] >= holdCycles) clientReq[idx] = 1'b0;
                    end else if (!clientReq[idx] && !clientAck[idx] && !draining
                                 && served[idx] < perClient) begin
                        newPayload(idx);
                        clientReq[idx] = 1'b1;
                        held[idx] = 0;
                    end
                end
            end
            lastAck = clientAck;
            clockStep();
            cycles++;
            for (idx = 0; idx < NumClients; idx++) begin
                if (clientAck[idx] && !lastAck[idx]) begin
                    grantLog.push_back(idx);
                    served[idx]++;
                end
            end
            if (grantLog.size() >= grantGoal) draining = 1'b1;
        end
        if (cycles >= limit) reportProblem("clients were not served within the cycle limit");
        waitIdle(4);
    endtask

    // assertion failures of the bound checker count against the test that saw them.
    task automatic closeTest(input string name);
        int newAsserts;
        newAsserts = dut_i.props_i.errorCount - assertSeen;
        assertSeen = dut_i.props_i.errorCount;
        if (newAsserts != 0) begin
            reportProblem($sformatf("%0d handshake assertions failed", newAsserts));
        end
        if (testErrors == 0) begin
            $display("test %0s: no errors", name);
            passCount++;
        end else begin
            $display("test %0s: %0d errors", name, testErrors);
            failCount++;
        end
        testErrors = 0;
    endtask

    // --------------------
    // tests
    // --------------------

    task automatic afterReset();
        repeat (3) begin
            if (clientAck !== '0) logMismatch("clientAck", 0, clientAck);
            if (busValid !== 1'b0) logMismatch("busValid", 0, busValid);
            if (busAddr !== '0) logMismatch("busAddr", 0, busAddr);
            if (busData !== '0) logMismatch("busData", 0, busData);
            clockStep();
        end
    endtask

    task automatic singleClient();
        logic [NumClients-1:0] ownMask;
        int                    idx;
        int                    waited;
        for (idx = 0; idx < NumClients; idx++) begin
            ownMask = 4'b0001 << idx;
            newPayload(idx);
            clientReq[idx] = 1'b1;
            waited = 0;
            while (!clientAck[idx] && waited < AckLimit) begin
                clockStep();
                waited++;
            end
            if (!clientAck[idx]) begin
                reportProblem($sformatf("client %0d never got ack", idx));
            end else begin
                // the owner keeps the bus a little while.
                repeat (3) begin
                    clockStep();
                    if (clientAck !== ownMask) logMismatch("clientAck", ownMask, clientAck);
                    if (busValid !== 1'b1) logMismatch("busValid", 1, busValid);
                    if (busAddr !== clientAddr[idx]) logMismatch("busAddr", clientAddr[idx], busAddr);
                    if (busData !== clientData[idx]) logMismatch("busData", clientData[idx], busData);
                end
                clientReq[idx] = 1'b0;
                clockStep();
                if (clientAck[idx] !== 1'b0) logMismatch("clientAck", 0, clientAck[idx]);
                if (busValid !== 1'b1) logMismatch("busValid", 1, busValid);
                clockStep();
                if (busValid !== 1'b0) logMismatch("busValid", 0, busValid);
            end
            waitIdle(4);
        end
    endtask

    task automatic mutualExclusion();
        int counts [NumClients];
        int idx;
        int k;
        serveClients(4'b1111, 1, 1, NumClients, MutualBudget);
        for (idx = 0; idx < NumClients; idx++) counts[idx] = 0;
        for (k = 0; k < grantLog.size(); k++) counts[grantLog[k]]++;
        for (idx = 0; idx < NumClients; idx++) begin
            if (counts[idx] != 1) begin
                reportProblem($sformatf("client %0d was granted %0d times", idx, counts[idx]));
            end
        end
    endtask

    task automatic noStarvation();
        int counts [NumClients];
        int gap [NumClients];
        int worst [NumClients];
        int idx;
        int k;
        serveClients(4'b1111, 2, 1000, 16, StarveBudget);
        if (grantLog.size() < 16) reportProblem("fewer than sixteen grants were seen");
        for (idx = 0; idx < NumClients; idx++) begin
            counts[idx] = 0;
            gap[idx]    = 0;
            worst[idx]  = 0;
        end
        // every client asks all the time, so grants to others count as waiting.
        for (k = 0; k < 16 && k < grantLog.size(); k++) begin
            for (idx = 0; idx < NumClients; idx++) begin
                if (grantLog[k] == idx) begin
                    counts[idx]++;
                    gap[idx] = 0;
                end else begin
                    gap[idx]++;
                    if (gap[idx] > worst[idx]) worst[idx] = gap[idx];
                end
            end
        end
        for (idx = 0; idx < NumClients; idx++) begin
            if (counts[idx] < 3) begin
                reportProblem($sformatf("client %0d got only %0d grants", idx, counts[idx]));
            end
            if (worst[idx] > 4) begin
                reportProblem($sformatf("client %0d waited through %0d grants", idx, worst[idx]));
            end
        end
    endtask

    task automatic siblingAlternation();
        int k;
        // clients 0 and 1 share the first leaf.
        serveClients(4'b0011, 1, 1000, 8, SiblingBudget);
        if (grantLog.size() < 8) reportProblem("fewer than eight grants were seen");
        for (k = 1; k < 8 && k < grantLog.size(); k++) begin
            if (grantLog[k] == grantLog[k-1]) begin
                reportProblem($sformatf("client %0d was granted twice in a row", grantLog[k]));
            end
        end
    endtask

    task automatic backPressure();
        int waited;
        int idx;
        newPayload(2);
        clientReq[2] = 1'b1;
        waited = 0;
        while (!clientAck[2] && waited < AckLimit) begin
            clockStep();
            waited++;
        end
        if (!clientAck[2]) begin
            reportProblem("client 2 never got ack");
        end
        // the others ask while client 2 keeps the bus.
        for (idx = 0; idx < NumClients; idx++) begin
            if (idx != 2) begin
                newPayload(idx);
                clientReq[idx] = 1'b1;
            end
        end
        repeat (12) begin
            clockStep();
            if (clientAck !== 4'b0100) logMismatch("clientAck", 4'b0100, clientAck);
            if (busAddr !== clientAddr[2]) logMismatch("busAddr", clientAddr[2], busAddr);
            if (busData !== clientData[2]) logMismatch("busData", clientData[2], busData);
        end
        clientReq[2] = 1'b0;
        serveClients(4'b1011, 1, 1, 3, BackBudget - 30);
        if (grantLog.size() != 3) reportProblem("the waiting clients were not each served once");
    endtask

    // --------------------
    // main sequence
    // --------------------

    initial begin
        reset      = 1'b1;
        clientReq  = '0;
        rngState   = 32'h43f446c2;
        testErrors = 0;
        assertSeen = 0;
        passCount  = 0;
        failCount  = 0;
        for (int idx = 0; idx < NumClients; idx++) begin
            clientAddr[idx] = '0;
            clientData[idx] = '0;
        end
        repeat (ResetCycles) @(posedge clk);
        #1;
        reset = 1'b0;

        afterReset();
        closeTest("afterReset");
        singleClient();
        closeTest("singleClient");
        mutualExclusion();
        closeTest("mutualExclusion");
        noStarvation();
        closeTest("noStarvation");
        siblingAlternation();
        closeTest("siblingAlternation");
        backPressure();
        closeTest("backPressure");

        $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
